//--- verilog/alu_pkg.sv
package alu_pkg;

    localparam int DATA_W      = 32;
    localparam int NIB_N       = DATA_W / 4;    // nibbles in the carry chain
    localparam int FLAG_BYTE_W = 8;

    // bit positions inside the one-hot width field
    localparam int W_BYTE = 0;
    localparam int W_WORD = 1;
    localparam int W_LONG = 2;

    typedef logic [2:0] width_t;                // all zero means no operation

    typedef enum logic [4:0] {
        OP_MOVE = 5'd0,
        OP_ADD  = 5'd1,
        OP_ADC  = 5'd2,
        OP_SUB  = 5'd3,
        OP_SBC  = 5'd4,
        OP_CP   = 5'd5,
        OP_NEG  = 5'd6,
        OP_AND  = 5'd7,
        OP_OR   = 5'd8,
        OP_XOR  = 5'd9,
        OP_CPL  = 5'd10,
        OP_SCF  = 5'd11,
        OP_RCF  = 5'd12,
        OP_CCF  = 5'd13,
        OP_ZCF  = 5'd14,
        OP_EXFF = 5'd15
    } alu_op_t;

    typedef struct packed {
        logic s;                                // sign
        logic z;                                // zero
        logic h;                                // half carry
        logic v;                                // overflow or parity
        logic n;                                // subtract
        logic c;                                // carry
    } flags_t;

    typedef struct packed {
        alu_op_t           op;
        width_t            width;
        logic [DATA_W-1:0] dst;
        logic [DATA_W-1:0] src;
    } alu_req_t;

    typedef struct packed {
        logic              hit;                 // unit owns this opcode
        logic              wr_data;             // result goes to dout
        logic [DATA_W-1:0] result;
        flags_t            nx_flags;
    } unit_out_t;

    // top bit of x at the operation width
    function automatic logic width_msb(input width_t w, input logic [DATA_W-1:0] x);
        return w[W_BYTE] ? x[7] : w[W_WORD] ? x[15] : x[DATA_W-1];
    endfunction

    // x is zero within the operation width
    function automatic logic width_zero(input width_t w, input logic [DATA_W-1:0] x);
        return w[W_BYTE] ? (x[7:0] == '0) : w[W_WORD] ? (x[15:0] == '0) : (x == '0);
    endfunction

endpackage

//--- verilog/alu_arith.sv
module alu_arith (
    input  alu_pkg::alu_req_t  req,
    input  alu_pkg::flags_t    flags,
    output alu_pkg::unit_out_t out
);

    logic                        is_add;       // ADD, ADC
    logic                        is_sub;       // SUB, SBC, CP
    logic                        is_neg;
    logic [alu_pkg::DATA_W-1:0]  opa;
    logic [alu_pkg::DATA_W-1:0]  opb;          // inverted for subtraction
    logic                        cin;
    logic [alu_pkg::DATA_W-1:0]  sum;
    logic [alu_pkg::NIB_N-1:0]   nib_c;        // carry out of each nibble
    logic                        half_c;
    logic                        top_cin;      // carry into the top bit of the width
    logic                        top_cout;     // carry out of the width

    assign is_add = (req.op == alu_pkg::OP_ADD) || (req.op == alu_pkg::OP_ADC);
    assign is_sub = (req.op == alu_pkg::OP_SUB) || (req.op == alu_pkg::OP_SBC) ||
                    (req.op == alu_pkg::OP_CP);
    assign is_neg = req.op == alu_pkg::OP_NEG;

    // subtraction runs as a + ~b + 1, NEG as 0 + ~dst + 1
    assign opa = is_neg ? '0 : req.dst;
    assign opb = is_neg ? ~req.dst : (is_add ? req.src : ~req.src);

    // a borrow in is a missing carry in
    assign cin = is_add ? ((req.op == alu_pkg::OP_ADC) && flags.c) :
                          ~((req.op == alu_pkg::OP_SBC) && flags.c);

    always_comb begin : nibble_chain
        logic       cy;
        logic [4:0] nsum;
        cy = cin;
        for (int i = 0; i < alu_pkg::NIB_N; i++) begin
            nsum           = {1'b0, opa[4*i +: 4]} + {1'b0, opb[4*i +: 4]} + {4'd0, cy};
            sum[4*i +: 4]  = nsum[3:0];
            cy             = nsum[4];
            nib_c[i]       = cy;
        end
    end

    assign half_c = nib_c[0];

    // byte carry leaves nibble 1, word carry nibble 3
    assign top_cout = req.width[alu_pkg::W_BYTE] ? nib_c[1] :
                      req.width[alu_pkg::W_WORD] ? nib_c[3] : nib_c[alu_pkg::NIB_N-1];

    // carry into the sign bit, recovered from the operand and sum bits
    assign top_cin = alu_pkg::width_msb(req.width, opa ^ opb ^ sum);

    always_comb begin
        out.hit      = is_add || is_sub || is_neg;
        out.wr_data  = out.hit && (req.op != alu_pkg::OP_CP);   // CP only sets flags
        out.result   = sum;
        out.nx_flags = flags;
        if (out.hit) begin
            out.nx_flags.s = alu_pkg::width_msb(req.width, sum);
            out.nx_flags.z = alu_pkg::width_zero(req.width, sum);
            out.nx_flags.h = is_add ? half_c : ~half_c;
            out.nx_flags.v = top_cin ^ top_cout;                 // signed overflow
            out.nx_flags.n = ~is_add;
            out.nx_flags.c = is_add ? top_cout : ~top_cout;
        end
    end

endmodule

//--- verilog/alu_logic.sv
module alu_logic (
    input  logic               clk,
    input  logic               rst,
    input  alu_pkg::alu_req_t  req,
    input  alu_pkg::flags_t    flags,
    input  logic               issue,
    output alu_pkg::unit_out_t out
);

    alu_pkg::flags_t            shadow;        // alternate flag set for EXFF
    logic [alu_pkg::DATA_W-1:0] res;
    logic                       parity_even;

    always_comb begin
        case (req.op)
            alu_pkg::OP_AND: res = req.dst & req.src;
            alu_pkg::OP_OR:  res = req.dst | req.src;
            alu_pkg::OP_XOR: res = req.dst ^ req.src;
            alu_pkg::OP_CPL: res = ~req.src;
            default:         res = req.src;    // MOVE
        endcase
    end

    // byte ops check 8 bits, word and long check 16
    assign parity_even = req.width[alu_pkg::W_BYTE] ? ~^res[7:0] : ~^res[15:0];

    always_comb begin
        out.hit      = 1'b1;
        out.wr_data  = 1'b0;
        out.result   = res;
        out.nx_flags = flags;
        case (req.op)
            alu_pkg::OP_MOVE: begin
                out.wr_data = 1'b1;                    // flags untouched
            end
            alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR: begin
                out.wr_data    = 1'b1;
                out.nx_flags.s = alu_pkg::width_msb(req.width, res);
                out.nx_flags.z = alu_pkg::width_zero(req.width, res);
                out.nx_flags.h = req.op == alu_pkg::OP_AND;
                out.nx_flags.v = parity_even;
                out.nx_flags.n = 1'b0;
                out.nx_flags.c = 1'b0;
            end
            alu_pkg::OP_CPL: begin
                out.wr_data    = 1'b1;
                out.nx_flags.h = 1'b1;
                out.nx_flags.n = 1'b1;
            end
            alu_pkg::OP_SCF: begin
                out.nx_flags.c = 1'b1;
                out.nx_flags.n = 1'b0;
                out.nx_flags.h = 1'b0;
            end
            alu_pkg::OP_RCF: begin
                out.nx_flags.c = 1'b0;
                out.nx_flags.n = 1'b0;
                out.nx_flags.h = 1'b0;
            end
            alu_pkg::OP_CCF: begin
                out.nx_flags.c = ~flags.c;
                out.nx_flags.n = 1'b0;
            end
            alu_pkg::OP_ZCF: begin
                out.nx_flags.c = ~flags.z;
                out.nx_flags.n = 1'b0;
            end
            alu_pkg::OP_EXFF: begin
                out.nx_flags = shadow;                 // swap with live flags
            end
            default: begin
                out.hit = 1'b0;                        // arithmetic or unknown
            end
        endcase
    end

    // live flags move into the shadow as the EXFF is accepted
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shadow <= '0;
        end else if (issue && (req.op == alu_pkg::OP_EXFF)) begin
            shadow <= flags;
        end
    end

endmodule

//--- verilog/alu_flag_reg.sv
module alu_flag_reg (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  alu_pkg::width_t                   width,
    input  alu_pkg::unit_out_t                arith,
    input  alu_pkg::unit_out_t                logic_out,
    output logic                              issue,
    output alu_pkg::flags_t                   flags,
    output logic [alu_pkg::DATA_W-1:0]        dout,
    output logic [alu_pkg::FLAG_BYTE_W-1:0]   flag_byte,
    output logic                              done
);

    alu_pkg::unit_out_t sel;                   // proposal of the claiming unit

    // width zero is an empty slot
    assign issue = cen && (width != '0);

    always_comb begin
        if (arith.hit) begin
            sel = arith;
        end else if (logic_out.hit) begin
            sel = logic_out;
        end else begin
            sel = '0;                          // unclaimed opcode acts as a no-op
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
            dout  <= '0;
            done  <= 1'b0;
        end else if (cen) begin
            done <= issue;                     // holds while cen is low
            if (issue && sel.hit) begin
                flags <= sel.nx_flags;
            end
            if (issue && sel.wr_data) begin
                dout <= sel.result;
            end
        end
    end

    // external layout: S Z - H - V N C
    assign flag_byte = {
        flags.s,
        flags.z,
        1'b0,
        flags.h,
        1'b0,
        flags.v,
        flags.n,
        flags.c
    };

endmodule

//--- verilog/tlcs_alu.sv
module tlcs_alu (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  alu_pkg::alu_req_t                 req,
    output logic [alu_pkg::DATA_W-1:0]        dout,
    output logic [alu_pkg::FLAG_BYTE_W-1:0]   flags,
    output logic                              done
);

    alu_pkg::unit_out_t arith_out;
    alu_pkg::unit_out_t logic_out;
    alu_pkg::flags_t    cur_flags;             // architectural flags
    logic               issue;                 // accepted command strobe

    alu_arith arith0 (
        .req       (req),
        .flags     (cur_flags),
        .out       (arith_out)
    );

    alu_logic logic0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .flags     (cur_flags),
        .issue     (issue),
        .out       (logic_out)
    );

    alu_flag_reg freg0 (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .width     (req.width),
        .arith     (arith_out),
        .logic_out (logic_out),
        .issue     (issue),
        .flags     (cur_flags),
        .dout      (dout),
        .flag_byte (flags),
        .done      (done)
    );

endmodule

//--- include/alu_ref.svh
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

typedef struct packed {
    logic [alu_pkg::DATA_W-1:0] dout;
    alu_pkg::flags_t            flags;
    alu_pkg::flags_t            shadow;     // alternate set swapped by EXFF
} ref_state_t;

ref_state_t model;
logic       model_done;

// operand size in bits for a one-hot width
function automatic int bits_of(input alu_pkg::width_t w);
    if (w[alu_pkg::W_BYTE])
        return 8;
    if (w[alu_pkg::W_WORD])
        return 16;
    return 32;
endfunction

function automatic logic [31:0] low_mask(input int bits);
    return (bits >= 32) ? 32'hffff_ffff : ((32'd1 << bits) - 32'd1);
endfunction

function automatic logic [7:0] flag_byte_of(input alu_pkg::flags_t f);
    return {f.s, f.z, 1'b0, f.h, 1'b0, f.v, f.n, f.c};
endfunction

// next model state after one accepted command
function automatic ref_state_t ref_next(input alu_pkg::alu_req_t r, input ref_state_t st);
    ref_state_t  nx;
    int          bits;
    logic [31:0] mask;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        cb;
    logic [32:0] wide;
    logic [4:0]  nib;
    nx   = st;
    bits = bits_of(r.width);
    mask = low_mask(bits);
    res  = st.dout;
    case (r.op)
        alu_pkg::OP_ADD, alu_pkg::OP_ADC: begin
            a    = r.dst;
            b    = r.src;
            cb   = (r.op == alu_pkg::OP_ADC) && st.flags.c;
            res  = a + b + {31'd0, cb};
            wide = {1'b0, a & mask} + {1'b0, b & mask} + {32'd0, cb};
            nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cb};
            nx.flags.c = wide[bits];
            nx.flags.h = nib[4];
            nx.flags.v = (a[bits-1] == b[bits-1]) && (res[bits-1] != a[bits-1]);
            nx.flags.n = 1'b0;
            nx.dout    = res;
        end
        alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP, alu_pkg::OP_NEG: begin
            a   = (r.op == alu_pkg::OP_NEG) ? 32'd0 : r.dst;
            b   = (r.op == alu_pkg::OP_NEG) ? r.dst : r.src;
            cb  = (r.op == alu_pkg::OP_SBC) && st.flags.c;  // borrow in
            res = a - b - {31'd0, cb};
            nx.flags.c = {1'b0, a & mask} < ({1'b0, b & mask} + {32'd0, cb});
            nx.flags.h = {1'b0, a[3:0]} < ({1'b0, b[3:0]} + {4'd0, cb});
            nx.flags.v = (a[bits-1] != b[bits-1]) && (res[bits-1] != a[bits-1]);
            nx.flags.n = 1'b1;
            if (r.op != alu_pkg::OP_CP)
                nx.dout = res;
        end
        alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR: begin
            if (r.op == alu_pkg::OP_AND)
                res = r.dst & r.src;
            else if (r.op == alu_pkg::OP_OR)
                res = r.dst | r.src;
            else
                res = r.dst ^ r.src;
            nx.flags.h = (r.op == alu_pkg::OP_AND);
            nx.flags.v = (bits == 8) ? ~^res[7:0] : ~^res[15:0];   // even parity
            nx.flags.n = 1'b0;
            nx.flags.c = 1'b0;
            nx.dout    = res;
        end
        alu_pkg::OP_CPL: begin
            nx.dout    = ~r.src;
            nx.flags.h = 1'b1;
            nx.flags.n = 1'b1;
        end
        alu_pkg::OP_MOVE: nx.dout = r.src;
        alu_pkg::OP_SCF: begin
            nx.flags.c = 1'b1;
            nx.flags.n = 1'b0;
            nx.flags.h = 1'b0;
        end
        alu_pkg::OP_RCF: begin
            nx.flags.c = 1'b0;
            nx.flags.n = 1'b0;
            nx.flags.h = 1'b0;
        end
        alu_pkg::OP_CCF: begin
            nx.flags.c = ~st.flags.c;
            nx.flags.n = 1'b0;
        end
        alu_pkg::OP_ZCF: begin
            nx.flags.c = ~st.flags.z;
            nx.flags.n = 1'b0;
        end
        alu_pkg::OP_EXFF: begin
            nx.flags  = st.shadow;
            nx.shadow = st.flags;
        end
        default: ;                              // unclaimed opcode, nothing moves
    endcase
    // sign and zero follow the width for every data-producing op except MOVE and CPL
    if ((r.op inside {alu_pkg::OP_ADD, alu_pkg::OP_ADC, alu_pkg::OP_SUB, alu_pkg::OP_SBC,
                      alu_pkg::OP_CP, alu_pkg::OP_NEG, alu_pkg::OP_AND, alu_pkg::OP_OR,
                      alu_pkg::OP_XOR})) begin
        nx.flags.s = res[bits-1];
        nx.flags.z = (res & mask) == 32'd0;
    end
    return nx;
endfunction

`endif

//--- verification/alu_tb.sv
module alu_tb;

    logic              clk;
    logic              rst;
    logic              cen;
    alu_pkg::alu_req_t req;
    logic [31:0]       dout;
    logic [7:0]        flag_byte;
    logic              done;

    int check_cnt   = 0;
    int err_cnt     = 0;
    int timeout_cnt = 0;
    int cmd_cnt     = 0;                        // accepted commands seen by the model

    `include "alu_ref.svh"

    tlcs_alu dut0 (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .req   (req),
        .dout  (dout),
        .flags (flag_byte),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic send(input alu_pkg::alu_op_t op, input alu_pkg::width_t w,
                        input logic [31:0] d, input logic [31:0] s);
        alu_pkg::alu_req_t r;
        r.op    = op;
        r.width = w;
        r.dst   = d;
        r.src   = s;
        @(posedge clk);
        req <= r;
        cen <= 1'b1;
    endtask

    // command sits on the bus with cen low
    task automatic hold_stalled(input alu_pkg::alu_op_t op, input logic [31:0] d, int cycles);
        alu_pkg::alu_req_t r;
        r.op    = op;
        r.width = 3'b001;
        r.dst   = d;
        r.src   = ~d;
        repeat (cycles) begin
            @(posedge clk);
            req <= r;
            cen <= 1'b0;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            cen <= 1'b0;
        end
    endtask

    task automatic wait_for_done(input int limit);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!done && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!done) begin
            timeout_cnt++;
            $display("Timeout at %0t: done did not rise within %0d cycles", $time, limit);
        end
    endtask

    function automatic alu_pkg::width_t pick_width();
        case ($urandom_range(0, 2))
            0: return 3'b001;
            1: return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    // mostly random, with the values that sit on carry and overflow edges
    function automatic logic [31:0] pick_operand();
        logic [31:0] v;
        v = $urandom;
        case ($urandom_range(0, 19))
            0: v = 32'h0000_0000;
            1: v = 32'h0000_007f;
            2: v = 32'h0000_0080;
            3: v = 32'h0000_00ff;
            4: v = 32'h0000_7fff;
            5: v = 32'hffff_8000;
            6: v = 32'h7fff_ffff;
            7: v = 32'h8000_0000;
            8: v = 32'hffff_ffff;
            9: v = 32'h0000_000f;
            default: ;
        endcase
        return v;
    endfunction

    function automatic alu_pkg::alu_op_t pick_arith_op();
        case ($urandom_range(0, 5))
            0: return alu_pkg::OP_ADD;
            1: return alu_pkg::OP_ADC;
            2: return alu_pkg::OP_SUB;
            3: return alu_pkg::OP_SBC;
            4: return alu_pkg::OP_CP;
            default: return alu_pkg::OP_NEG;
        endcase
    endfunction

    function automatic alu_pkg::alu_op_t pick_logic_op();
        case ($urandom_range(0, 4))
            0: return alu_pkg::OP_AND;
            1: return alu_pkg::OP_OR;
            2: return alu_pkg::OP_XOR;
            3: return alu_pkg::OP_CPL;
            default: return alu_pkg::OP_MOVE;
        endcase
    endfunction

    // model follows each edge; outputs are checked at the falling edge
    initial begin : compare
        alu_pkg::alu_req_t pend_req;
        logic              pend_cen;
        int                cnt;
        model      = '0;
        model_done = 1'b0;
        cnt        = 0;
        @(negedge clk);
        while (rst !== 1'b0 && cnt < 40) begin
            @(negedge clk);
            cnt++;
        end
        if (rst !== 1'b0) begin
            timeout_cnt++;
            $display("Timeout at %0t: reset was never released", $time);
        end
        forever begin
            check_value("dout", dout, model.dout);
            check_value("flags", {24'd0, flag_byte}, {24'd0, flag_byte_of(model.flags)});
            check_value("done", {31'd0, done}, {31'd0, model_done});
            pend_req = req;
            pend_cen = cen;
            @(negedge clk);
            if (pend_cen) begin
                model_done = pend_req.width != '0;
                if (pend_req.width != '0) begin
                    model = ref_next(pend_req, model);
                    cmd_cnt++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [4:0]        code;
        void'($urandom(32'h4b17));
        rst  = 1'b1;
        cen  = 1'b0;
        req  = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        idle(3);                                 // reset state checked here

        // carry, half carry and overflow edges
        send(alu_pkg::OP_ADD, 3'b001, 32'h0000_007f, 32'h0000_0001);
        send(alu_pkg::OP_ADD, 3'b001, 32'h1234_56ff, 32'h0000_0001);
        send(alu_pkg::OP_ADC, 3'b001, 32'h0000_0010, 32'h0000_0020);
        send(alu_pkg::OP_ADD, 3'b010, 32'h0000_7fff, 32'h0000_0001);
        send(alu_pkg::OP_ADD, 3'b010, 32'h0000_ffff, 32'h0000_0001);
        send(alu_pkg::OP_ADD, 3'b100, 32'h7fff_ffff, 32'h0000_0001);
        send(alu_pkg::OP_ADD, 3'b100, 32'hffff_ffff, 32'h0000_0001);
        send(alu_pkg::OP_SUB, 3'b001, 32'h0000_0080, 32'h0000_0001);
        send(alu_pkg::OP_SUB, 3'b001, 32'h0000_0000, 32'h0000_0001);
        send(alu_pkg::OP_SBC, 3'b010, 32'h0000_0000, 32'h0000_0000);
        send(alu_pkg::OP_CP,  3'b100, 32'h0000_0005, 32'h0000_0005);
        send(alu_pkg::OP_NEG, 3'b001, 32'h0000_0080, 32'h0000_0000);
        send(alu_pkg::OP_NEG, 3'b010, 32'h0000_0000, 32'h0000_0000);
        send(alu_pkg::OP_NEG, 3'b100, 32'h0000_0001, 32'h0000_0000);
        repeat (200)
            send(pick_arith_op(), pick_width(), pick_operand(), pick_operand());
        idle(1);
        wait_for_done(10);

        // logic and MOVE, with a SUB now and then to stir the flags
        for (int i = 0; i < 160; i++) begin
            if (i % 4 == 3)
                send(alu_pkg::OP_SUB, pick_width(), pick_operand(), pick_operand());
            else
                send(pick_logic_op(), pick_width(), pick_operand(), pick_operand());
        end
        idle(1);
        wait_for_done(10);

        // carry-flag ops from known flags
        send(alu_pkg::OP_ADD, 3'b001, 32'h0000_00ff, 32'h0000_0001);   // C and Z set
        send(alu_pkg::OP_RCF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::OP_SCF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::OP_CCF, 3'b010, 32'h0, 32'h0);
        send(alu_pkg::OP_CCF, 3'b100, 32'h0, 32'h0);
        send(alu_pkg::OP_ZCF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::OP_SUB, 3'b001, 32'h0000_0005, 32'h0000_0003);   // Z clear
        send(alu_pkg::OP_ZCF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::OP_CPL, 3'b001, 32'h0, 32'h0000_00a5);          // H and N set
        send(alu_pkg::OP_SCF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::OP_CPL, 3'b010, 32'h0, 32'h0000_5a5a);
        send(alu_pkg::OP_RCF, 3'b001, 32'h0, 32'h0);
        idle(1);
        wait_for_done(10);

        // shadow swap around an arithmetic command
        send(alu_pkg::OP_ADD,  3'b001, 32'h0000_007f, 32'h0000_0001);
        send(alu_pkg::OP_EXFF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::OP_SUB,  3'b100, 32'h0000_0000, 32'h0000_0001);
        send(alu_pkg::OP_EXFF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::OP_EXFF, 3'b010, 32'h0, 32'h0);
        send(alu_pkg::OP_MOVE, 3'b100, 32'h0, 32'hcafe_f00d);
        idle(1);
        wait_for_done(10);

        // stalls, empty slots and an unclaimed opcode
        send(alu_pkg::OP_ADD, 3'b010, 32'h0000_1234, 32'h0000_4321);
        hold_stalled(alu_pkg::OP_SUB, 32'h0000_0077, 4);               // done holds high
        send(alu_pkg::OP_ADD, 3'b000, 32'h0000_0001, 32'h0000_0001);
        send(alu_pkg::OP_XOR, 3'b000, 32'hffff_ffff, 32'h0000_0001);
        send(alu_pkg::OP_SCF, 3'b001, 32'h0, 32'h0);
        send(alu_pkg::alu_op_t'(5'd20), 3'b001, 32'h0000_0011, 32'h0000_0022);
        for (int i = 0; i < 120; i++) begin
            code = 5'($urandom_range(0, 15));
            if (i % 17 == 5)
                hold_stalled(alu_pkg::alu_op_t'(code), pick_operand(), 2);
            else if (i % 13 == 7)
                send(alu_pkg::alu_op_t'(code), 3'b000, pick_operand(), pick_operand());
            else
                send(alu_pkg::alu_op_t'(code), pick_width(), pick_operand(), pick_operand());
        end
        send(alu_pkg::OP_MOVE, 3'b100, 32'h0, 32'h0bad_cafe);
        idle(1);
        wait_for_done(10);
        idle(3);

        $display("checks %0d, commands %0d, errors %0d, timeouts %0d",
                 check_cnt, cmd_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tlcs_alu.f
+incdir+include
verilog/alu_pkg.sv
verilog/alu_arith.sv
verilog/alu_logic.sv
verilog/alu_flag_reg.sv
verilog/tlcs_alu.sv
verification/alu_tb.sv

//--- Makefile
TOP = alu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f tlcs_alu.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
